// File: aexmPkg.sv
package aexmPkg;

   localparam int dataW = 32;
   localparam int memAddrW = 8;

   // opcode bit that selects the immediate form
   localparam int opcTypeBBit = 3;

   localparam logic [5:0] opAlu = 6'h00;
   localparam logic [5:0] opLink = 6'h26;

   // loads, register and immediate forms
   localparam logic [5:0] opLbu = 6'h30;
   localparam logic [5:0] opLhu = 6'h31;
   localparam logic [5:0] opLw = 6'h32;
   localparam logic [5:0] opLbui = 6'h38;
   localparam logic [5:0] opLhui = 6'h39;
   localparam logic [5:0] opLwi = 6'h3A;

   // stores, register and immediate forms
   localparam logic [5:0] opSb = 6'h34;
   localparam logic [5:0] opSh = 6'h35;
   localparam logic [5:0] opSw = 6'h36;
   localparam logic [5:0] opSbi = 6'h3C;
   localparam logic [5:0] opShi = 6'h3D;
   localparam logic [5:0] opSwi = 6'h3E;

   // access size in opcode bits 1:0
   localparam logic [1:0] sizeByte = 2'd0;
   localparam logic [1:0] sizeHalf = 2'd1;
   localparam logic [1:0] sizeWord = 2'd2;

   // write-back source select
   localparam logic [1:0] wbResult = 2'd0;
   localparam logic [1:0] wbLink = 2'd1;
   localparam logic [1:0] wbLoad = 2'd2;
   localparam logic [1:0] wbNone = 2'd3;

   // load/store port FSM
   localparam logic [1:0] stIdle = 2'd0;
   localparam logic [1:0] stRequest = 2'd1;
   localparam logic [1:0] stLoadWait = 2'd2;

   typedef struct packed {
      logic [5:0] opc;
      logic [4:0] rd;
      logic [4:0] ra;
      logic [4:0] rb;
      logic [10:0] unused;
   } instTypeA_s;

   typedef struct packed {
      logic [5:0] opc;
      logic [4:0] rd;
      logic [4:0] ra;
      logic [15:0] imm;
   } instTypeB_s;

   typedef union packed {
      instTypeA_s typeA;
      instTypeB_s typeB;
   } instWord_u;

endpackage

// File: memBusIf.sv
`timescale 1ns/1ns

interface memBusIf;
   import aexmPkg::*;

   logic req;
   logic we;
   logic [memAddrW-1:0] addr;
   logic [3:0] sel;
   logic [dataW-1:0] wdata;
   logic [dataW-1:0] rdata;
   logic gnt;

   // requester side
   modport master (
      output req, we, addr, sel, wdata,
      input gnt, rdata
   );

   // arbiter port that faces one requester
   modport arbiter (
      input req, we, addr, sel, wdata,
      output gnt, rdata
   );

   // the RAM itself, always ready
   modport ram (
      input req, we, addr, sel, wdata,
      output gnt, rdata
   );

endinterface

// File: regBank.sv
`timescale 1ns/1ns

module regBank (
   input logic gclk,
   input logic [4:0] raddr,
   output logic [31:0] rdata,
   input logic we,
   input logic [4:0] waddr,
   input logic [31:0] wdata
);

   logic [31:0] mem [32];

   // start from a cleared bank
   initial begin
      for (int i = 0; i < 32; i++) begin
         mem[i] = '0;
      end
   end

   // read returns the old contents on a same-address write
   always_ff @(posedge gclk) begin
      if (we) begin
         mem[waddr] <= wdata;
      end
      rdata <= mem[raddr];
   end

endmodule

// File: regFile.sv
`timescale 1ns/1ns

module regFile (
   input logic gclk,
   input logic rstN,
   input logic [4:0] raA,
   input logic [4:0] raB,
   input logic [4:0] raD,
   input logic [1:0] storeSize,
   input logic [1:0] wbSel,
   input logic [4:0] wbAddr,
   input logic [aexmPkg::dataW-1:0] wbResult,
   input logic [29:0] wbLink,
   input logic [aexmPkg::dataW-1:0] wbLoad,
   output logic [aexmPkg::dataW-1:0] regA,
   output logic [aexmPkg::dataW-1:0] regB,
   output logic [aexmPkg::dataW-1:0] storeData
);
   import aexmPkg::*;

   logic [dataW-1:0] wbData;
   logic [dataW-1:0] wrData;
   logic [dataW-1:0] fwdData;
   logic [dataW-1:0] bankAOut;
   logic [dataW-1:0] bankBOut;
   logic [dataW-1:0] bankDOut;
   logic [dataW-1:0] storeSrc;
   logic [4:0] wrAddr;
   logic doWrite;
   logic wrEn;
   logic hitA;
   logic hitB;
   logic hitD;

   // write-back mux, the port names hide the package selects
   always_comb begin
      case (wbSel)
         aexmPkg::wbLink: wbData = {wbLink, 2'b00};
         aexmPkg::wbLoad: wbData = wbLoad;
         default: wbData = wbResult;
      endcase
   end

   // r0 never written after reset
   assign doWrite = (wbSel != wbNone) && (wbAddr != 5'd0);

   // reset forces zero into r0
   assign wrEn = !rstN || doWrite;
   assign wrAddr = rstN ? wbAddr : 5'd0;
   assign wrData = rstN ? wbData : '0;

   regBank bankA (
      .gclk(gclk),
      .raddr(raA),
      .rdata(bankAOut),
      .we(wrEn),
      .waddr(wrAddr),
      .wdata(wrData)
   );

   regBank bankB (
      .gclk(gclk),
      .raddr(raB),
      .rdata(bankBOut),
      .we(wrEn),
      .waddr(wrAddr),
      .wdata(wrData)
   );

   regBank bankD (
      .gclk(gclk),
      .raddr(raD),
      .rdata(bankDOut),
      .we(wrEn),
      .waddr(wrAddr),
      .wdata(wrData)
   );

   // note which read port saw a write to the same register
   always_ff @(posedge gclk or negedge rstN) begin
      if (!rstN) begin
         hitA <= 1'b0;
         hitB <= 1'b0;
         hitD <= 1'b0;
      end else begin
         hitA <= doWrite && (wbAddr == raA);
         hitB <= doWrite && (wbAddr == raB);
         hitD <= doWrite && (wbAddr == raD);
      end
   end

   always_ff @(posedge gclk) begin
      fwdData <= wbData;
   end

   assign regA = hitA ? fwdData : bankAOut;
   assign regB = hitB ? fwdData : bankBOut;
   assign storeSrc = hitD ? fwdData : bankDOut;

   // store sizer, lanes repeated across the word
   always_comb begin
      case (storeSize)
         sizeByte: storeData = {4{storeSrc[7:0]}};
         sizeHalf: storeData = {2{storeSrc[15:0]}};
         default: storeData = storeSrc;
      endcase
   end

endmodule

// File: lsuPort.sv
`timescale 1ns/1ns

module lsuPort (
   input logic gclk,
   input logic rstN,
   input aexmPkg::instWord_u inst,
   input logic instValid,
   input logic [aexmPkg::dataW-1:0] result,
   input logic [29:0] pcLink,
   input logic [aexmPkg::dataW-1:0] regA,
   input logic [aexmPkg::dataW-1:0] regB,
   input logic [aexmPkg::dataW-1:0] storeData,
   output logic [4:0] raA,
   output logic [4:0] raB,
   output logic [4:0] raD,
   output logic [1:0] storeSize,
   output logic [1:0] wbSel,
   output logic [4:0] wbAddr,
   output logic [aexmPkg::dataW-1:0] wbResult,
   output logic [29:0] wbLink,
   output logic [aexmPkg::dataW-1:0] wbLoad,
   output logic retire,
   output logic busy,
   memBusIf.master bus
);
   import aexmPkg::*;

   instWord_u instReg;
   logic [1:0] state;
   logic [1:0] stateNext;
   logic [5:0] opc;
   logic [1:0] memSize;
   logic isLoad;
   logic isStore;
   logic isMem;
   logic isTypeB;
   logic [dataW-1:0] offset;
   logic [dataW-1:0] byteAddr;

   always_ff @(posedge gclk) begin
      if (instValid) begin
         instReg <= inst;
         wbResult <= result;
         wbLink <= pcLink;
      end
   end

   // read addresses follow the new instruction in its valid cycle
   assign raA = instValid ? inst.typeA.ra : instReg.typeA.ra;
   assign raB = instValid ? inst.typeA.rb : instReg.typeA.rb;
   assign raD = instValid ? inst.typeA.rd : instReg.typeA.rd;

   assign opc = instReg.typeA.opc;
   assign memSize = opc[1:0];
   assign storeSize = memSize;
   assign isTypeB = opc[opcTypeBBit];
   assign isMem = isLoad || isStore;

   always_comb begin
      isLoad = 1'b0;
      isStore = 1'b0;
      case (opc)
         opLbu, opLhu, opLw, opLbui, opLhui, opLwi: isLoad = 1'b1;
         opSb, opSh, opSw, opSbi, opShi, opSwi: isStore = 1'b1;
         default: ;
      endcase
   end

   // effective address, imm sign-extended for type B
   assign offset = isTypeB ? {{16{instReg.typeB.imm[15]}}, instReg.typeB.imm} : regB;
   assign byteAddr = regA + offset;

   assign bus.req = (state == stRequest) && isMem;
   assign bus.we = isStore;
   assign bus.addr = byteAddr[memAddrW+1:2];
   assign bus.wdata = storeData;

   always_comb begin
      case (memSize)
         sizeByte: bus.sel = 4'b0001 << byteAddr[1:0];
         sizeHalf: bus.sel = byteAddr[1] ? 4'b1100 : 4'b0011;
         sizeWord: bus.sel = 4'b1111;
         default: bus.sel = 4'b0000;
      endcase
   end

   // load sizer, zero-extended
   always_comb begin
      case (bus.sel)
         4'b0001: wbLoad = {24'd0, bus.rdata[7:0]};
         4'b0010: wbLoad = {24'd0, bus.rdata[15:8]};
         4'b0100: wbLoad = {24'd0, bus.rdata[23:16]};
         4'b1000: wbLoad = {24'd0, bus.rdata[31:24]};
         4'b0011: wbLoad = {16'd0, bus.rdata[15:0]};
         4'b1100: wbLoad = {16'd0, bus.rdata[31:16]};
         default: wbLoad = bus.rdata;
      endcase
   end

   always_comb begin
      stateNext = state;
      retire = 1'b0;
      case (state)
         stIdle: begin
            if (instValid) begin
               stateNext = stRequest;
            end
         end
         stRequest: begin
            if (!isMem) begin
               retire = 1'b1;
            end else if (bus.gnt) begin
               if (isStore) begin
                  retire = 1'b1;
               end else begin
                  stateNext = stLoadWait;
               end
            end
         end
         stLoadWait: retire = 1'b1;
         default: stateNext = stIdle;
      endcase
      // next instruction may start in the retire cycle
      if (retire) begin
         stateNext = instValid ? stRequest : stIdle;
      end
   end

   always_ff @(posedge gclk or negedge rstN) begin
      if (!rstN) begin
         state <= stIdle;
      end else begin
         state <= stateNext;
      end
   end

   assign busy = instValid || (state != stIdle);
   assign wbAddr = instReg.typeA.rd;

   always_comb begin
      wbSel = wbNone;
      if (state == stRequest) begin
         if (opc == opAlu) begin
            wbSel = aexmPkg::wbResult;
         end else if (opc == opLink) begin
            wbSel = aexmPkg::wbLink;
         end
      end else if (state == stLoadWait) begin
         wbSel = aexmPkg::wbLoad;
      end
   end

endmodule

// File: busArbiter.sv
`timescale 1ns/1ns

module busArbiter (
   input logic gclk,
   input logic rstN,
   memBusIf.arbiter dbg,
   memBusIf.arbiter lsu,
   memBusIf.master ram
);

   logic dbgOwner;

   // debug wins, one access per cycle
   assign ram.req = dbg.req || lsu.req;
   assign ram.we = dbg.req ? dbg.we : lsu.we;
   assign ram.addr = dbg.req ? dbg.addr : lsu.addr;
   assign ram.sel = dbg.req ? dbg.sel : lsu.sel;
   assign ram.wdata = dbg.req ? dbg.wdata : lsu.wdata;

   assign dbg.gnt = dbg.req && ram.gnt;
   assign lsu.gnt = lsu.req && !dbg.req && ram.gnt;

   // owner of the last read gets the returned word
   always_ff @(posedge gclk or negedge rstN) begin
      if (!rstN) begin
         dbgOwner <= 1'b0;
      end else if (ram.req && !ram.we) begin
         dbgOwner <= dbg.req;
      end
   end

   assign dbg.rdata = dbgOwner ? ram.rdata : '0;
   assign lsu.rdata = dbgOwner ? '0 : ram.rdata;

endmodule

// File: dataRam.sv
`timescale 1ns/1ns

module dataRam (
   input logic gclk,
   memBusIf.ram bus
);
   import aexmPkg::*;

   logic [dataW-1:0] mem [2**memAddrW];

   initial begin
      for (int i = 0; i < 2**memAddrW; i++) begin
         mem[i] = '0;
      end
   end

   // single port, takes every request
   assign bus.gnt = bus.req;

   always_ff @(posedge gclk) begin
      if (bus.req) begin
         if (bus.we) begin
            for (int i = 0; i < 4; i++) begin
               if (bus.sel[i]) begin
                  mem[bus.addr][8*i +: 8] <= bus.wdata[8*i +: 8];
               end
            end
         end else begin
            bus.rdata <= mem[bus.addr];
         end
      end
   end

endmodule

// File: regLsuTop.sv
`timescale 1ns/1ns

module regLsuTop (
   input logic gclk,
   input logic rstN,
   input logic [aexmPkg::dataW-1:0] inst,
   input logic instValid,
   input logic [aexmPkg::dataW-1:0] result,
   input logic [29:0] pcLink,
   output logic [aexmPkg::dataW-1:0] regA,
   output logic [aexmPkg::dataW-1:0] regB,
   output logic retire,
   output logic busy,
   input logic dbgReq,
   input logic dbgWe,
   input logic [aexmPkg::memAddrW-1:0] dbgAddr,
   input logic [aexmPkg::dataW-1:0] dbgWdata,
   input logic [3:0] dbgSel,
   output logic [aexmPkg::dataW-1:0] dbgRdata,
   output logic dbgAck
);

   logic [4:0] raA;
   logic [4:0] raB;
   logic [4:0] raD;
   logic [1:0] storeSize;
   logic [1:0] wbSel;
   logic [4:0] wbAddr;
   logic [aexmPkg::dataW-1:0] wbResult;
   logic [29:0] wbLink;
   logic [aexmPkg::dataW-1:0] wbLoad;
   logic [aexmPkg::dataW-1:0] storeData;
   logic dbgRdPend;

   memBusIf lsuBus ();
   memBusIf dbgBus ();
   memBusIf ramBus ();

   lsuPort u_lsuPort (
      .gclk(gclk),
      .rstN(rstN),
      .inst(inst),
      .instValid(instValid),
      .result(result),
      .pcLink(pcLink),
      .regA(regA),
      .regB(regB),
      .storeData(storeData),
      .raA(raA),
      .raB(raB),
      .raD(raD),
      .storeSize(storeSize),
      .wbSel(wbSel),
      .wbAddr(wbAddr),
      .wbResult(wbResult),
      .wbLink(wbLink),
      .wbLoad(wbLoad),
      .retire(retire),
      .busy(busy),
      .bus(lsuBus)
   );

   regFile u_regFile (
      .gclk(gclk),
      .rstN(rstN),
      .raA(raA),
      .raB(raB),
      .raD(raD),
      .storeSize(storeSize),
      .wbSel(wbSel),
      .wbAddr(wbAddr),
      .wbResult(wbResult),
      .wbLink(wbLink),
      .wbLoad(wbLoad),
      .regA(regA),
      .regB(regB),
      .storeData(storeData)
   );

   busArbiter u_busArbiter (
      .gclk(gclk),
      .rstN(rstN),
      .dbg(dbgBus),
      .lsu(lsuBus),
      .ram(ramBus)
   );

   dataRam u_dataRam (
      .gclk(gclk),
      .bus(ramBus)
   );

   // debug pins drive the debug master directly
   assign dbgBus.req = dbgReq;
   assign dbgBus.we = dbgWe;
   assign dbgBus.addr = dbgAddr;
   assign dbgBus.sel = dbgSel;
   assign dbgBus.wdata = dbgWdata;
   assign dbgRdata = dbgBus.rdata;

   // read ack waits for the RAM output register
   always_ff @(posedge gclk or negedge rstN) begin
      if (!rstN) begin
         dbgRdPend <= 1'b0;
      end else begin
         dbgRdPend <= dbgBus.gnt && !dbgBus.we;
      end
   end

   assign dbgAck = (dbgBus.gnt && dbgBus.we) || dbgRdPend;

endmodule

// File: regLsu_assert.sv
`timescale 1ns/1ns

module regLsuAssert (
   input logic gclk,
   input logic rstN,
   input logic busy,
   input logic retire,
   input logic dbgAck,
   input logic dbgGnt,
   input logic lsuReq,
   input logic lsuGnt,
   input logic lsuWe,
   input logic [aexmPkg::memAddrW-1:0] lsuAddr,
   input logic [3:0] lsuSel,
   input logic [aexmPkg::dataW-1:0] lsuWdata
);

   logic anyFailure;

   initial begin
      anyFailure = 1'b0;
   end

   // retire only inside a busy window
   retireInBusy: assert property (@(posedge gclk) disable iff (!rstN) retire |-> busy)
      else begin
         anyFailure = 1'b1;
         $error("retire high while busy is low");
      end

   // the single RAM port serves one master per cycle
   oneGrant: assert property (@(posedge gclk) disable iff (!rstN) !(dbgGnt && lsuGnt))
      else begin
         anyFailure = 1'b1;
         $error("debug and load/store grants high together");
      end

   // a waiting load/store request keeps its fields
   holdRequest: assert property (@(posedge gclk) disable iff (!rstN)
      lsuReq && !lsuGnt |=> lsuReq && $stable({lsuWe, lsuAddr, lsuSel, lsuWdata}))
      else begin
         anyFailure = 1'b1;
         $error("load/store request changed before its grant");
      end

   quietInReset: assert property (@(posedge gclk) !rstN |-> !busy && !retire && !dbgAck)
      else begin
         anyFailure = 1'b1;
         $error("busy, retire or dbgAck high during reset");
      end

endmodule

bind regLsuTop regLsuAssert u_regLsuAssert (
   .gclk(gclk),
   .rstN(rstN),
   .busy(busy),
   .retire(retire),
   .dbgAck(dbgAck),
   .dbgGnt(dbgBus.gnt),
   .lsuReq(lsuBus.req),
   .lsuGnt(lsuBus.gnt),
   .lsuWe(lsuBus.we),
   .lsuAddr(lsuBus.addr),
   .lsuSel(lsuBus.sel),
   .lsuWdata(lsuBus.wdata)
);

// File: regLsuTb.sv
`timescale 1ns/1ns

module regLsuTb;
   import aexmPkg::*;

   localparam int timeoutCycles = 40;

   logic gclk;
   logic rstN;
   logic [31:0] inst;
   logic instValid;
   logic [31:0] result;
   logic [29:0] pcLink;
   logic [31:0] regA;
   logic [31:0] regB;
   logic retire;
   logic busy;
   logic dbgReq;
   logic dbgWe;
   logic [7:0] dbgAddr;
   logic [31:0] dbgWdata;
   logic [3:0] dbgSel;
   logic [31:0] dbgRdata;
   logic dbgAck;

   // reference state of the register file and the data RAM
   logic [31:0] regModel [32];
   logic [31:0] memModel [256];
   logic [31:0] readWord;
   logic [31:0] rnd;
   logic [31:0] addr;
   logic [15:0] imm;
   logic [5:0] opc;
   logic isB;
   int seed;

   regLsuTop u_regLsuTop (
      .gclk(gclk),
      .rstN(rstN),
      .inst(inst),
      .instValid(instValid),
      .result(result),
      .pcLink(pcLink),
      .regA(regA),
      .regB(regB),
      .retire(retire),
      .busy(busy),
      .dbgReq(dbgReq),
      .dbgWe(dbgWe),
      .dbgAddr(dbgAddr),
      .dbgWdata(dbgWdata),
      .dbgSel(dbgSel),
      .dbgRdata(dbgRdata),
      .dbgAck(dbgAck)
   );

   always #10 gclk = ~gclk;

   task automatic abortRun(string what);
      $display("%s", what);
      $display("tests failed");
      $fatal(1);
   endtask

   always @(negedge gclk) begin
      if (u_regLsuTop.u_regLsuAssert.anyFailure) begin
         abortRun("a concurrent assertion failed");
      end
   end

   task automatic reportMismatch(string name, logic [31:0] expVal, logic [31:0] actVal);
      abortRun($sformatf("error %s: expected %08h, actual %08h", name, expVal, actVal));
   endtask

   function automatic logic [31:0] encodeTypeA(logic [5:0] op, logic [4:0] rd, logic [4:0] ra,
                                               logic [4:0] rb);
      return {op, rd, ra, rb, 11'd0};
   endfunction

   function automatic logic [31:0] encodeTypeB(logic [5:0] op, logic [4:0] rd, logic [4:0] ra,
                                               logic [15:0] immVal);
      return {op, rd, ra, immVal};
   endfunction

   // byte address from the register model, imm sign-extended for type B
   function automatic logic [31:0] effectiveAddr(logic [5:0] op, logic [4:0] ra, logic [4:0] rb,
                                                 logic [15:0] immVal);
      if (op[3]) begin
         return regModel[ra] + {{16{immVal[15]}}, immVal};
      end else begin
         return regModel[ra] + regModel[rb];
      end
   endfunction

   function automatic logic [31:0] loadLane(logic [31:0] word, logic [1:0] size, logic [1:0] low);
      case (size)
         2'd0: return {24'd0, word[8*low +: 8]};
         2'd1: return low[1] ? {16'd0, word[31:16]} : {16'd0, word[15:0]};
         default: return word;
      endcase
   endfunction

   // replicated store lanes land only in the selected bytes
   function automatic logic [31:0] storeMerge(logic [31:0] old, logic [31:0] src, logic [1:0] size,
                                              logic [1:0] low);
      logic [31:0] lanes;
      logic [3:0] sel;
      logic [31:0] merged;
      case (size)
         2'd0: begin
            lanes = {4{src[7:0]}};
            sel = 4'b0001 << low;
         end
         2'd1: begin
            lanes = {2{src[15:0]}};
            sel = low[1] ? 4'b1100 : 4'b0011;
         end
         default: begin
            lanes = src;
            sel = 4'b1111;
         end
      endcase
      merged = old;
      for (int i = 0; i < 4; i++) begin
         if (sel[i]) begin
            merged[8*i +: 8] = lanes[8*i +: 8];
         end
      end
      return merged;
   endfunction

   task automatic waitRetire();
      int cycles;
      cycles = 0;
      @(negedge gclk);
      while (!retire) begin
         if (cycles == timeoutCycles) begin
            abortRun("retire never came");
         end else begin
            // busy stays high until the retire cycle
            assert (busy) else abortRun("busy dropped before retire");
            cycles++;
            @(negedge gclk);
         end
      end
   endtask

   task automatic issue(logic [31:0] word, logic [31:0] res, logic [29:0] link);
      @(posedge gclk);
      inst <= word;
      result <= res;
      pcLink <= link;
      instValid <= 1'b1;
      @(posedge gclk);
      instValid <= 1'b0;
      waitRetire();
   endtask

   task automatic writeReg(logic [4:0] rd, logic [31:0] value);
      issue(encodeTypeA(opAlu, rd, 5'd0, 5'd0), value, 30'd0);
      if (rd != 5'd0) begin
         regModel[rd] = value;
      end
   endtask

   task automatic writeLink(logic [4:0] rd, logic [29:0] link);
      issue(encodeTypeA(opLink, rd, 5'd0, 5'd0), 32'd0, link);
      if (rd != 5'd0) begin
         regModel[rd] = {link, 2'b00};
      end
   endtask

   // rd of zero, so only the read ports act
   task automatic checkRegs(string name, logic [4:0] ra, logic [4:0] rb);
      issue(encodeTypeA(opAlu, 5'd0, ra, rb), 32'hdeadbeef, 30'd0);
      assert (regA == regModel[ra]) else reportMismatch({name, " regA"}, regModel[ra], regA);
      assert (regB == regModel[rb]) else reportMismatch({name, " regB"}, regModel[rb], regB);
   endtask

   task automatic debugAccess(logic we, logic [7:0] index, logic [31:0] wdata,
                              output logic [31:0] rdata);
      int cycles;
      logic acked;
      cycles = 0;
      @(posedge gclk);
      dbgReq <= 1'b1;
      dbgWe <= we;
      dbgAddr <= index;
      dbgSel <= 4'hf;
      dbgWdata <= wdata;
      @(negedge gclk);
      acked = dbgAck;
      // debug has priority, so its first cycle is the grant cycle
      @(posedge gclk);
      dbgReq <= 1'b0;
      while (!acked) begin
         if (cycles == timeoutCycles) begin
            abortRun("debug ack never came");
         end else begin
            cycles++;
            @(negedge gclk);
            acked = dbgAck;
         end
      end
      rdata = dbgRdata;
   endtask

   task automatic debugWriteWord(logic [7:0] index, logic [31:0] data);
      debugAccess(1'b1, index, data, readWord);
      memModel[index] = data;
   endtask

   task automatic debugCheck(string name, logic [7:0] index);
      debugAccess(1'b0, index, 32'd0, readWord);
      assert (readWord == memModel[index]) else reportMismatch(name, memModel[index], readWord);
   endtask

   task automatic memOp(string name, logic [5:0] op, logic [4:0] rd, logic [4:0] ra,
                        logic [4:0] rb, logic [15:0] immVal);
      logic [31:0] word;
      logic [31:0] eff;
      logic [7:0] index;
      word = op[3] ? encodeTypeB(op, rd, ra, immVal) : encodeTypeA(op, rd, ra, rb);
      eff = effectiveAddr(op, ra, rb, immVal);
      index = eff[9:2];
      issue(word, 32'd0, 30'd0);
      // opcode bit 2 marks a store
      if (op[2]) begin
         memModel[index] = storeMerge(memModel[index], regModel[rd], op[1:0], eff[1:0]);
         debugCheck(name, index);
      end else begin
         if (rd != 5'd0) begin
            regModel[rd] = loadLane(memModel[index], op[1:0], eff[1:0]);
         end
         checkRegs(name, rd, ra);
      end
   endtask

   // the store starts in the retire cycle of the write to its source
   task automatic aluThenStore(string name, logic [4:0] rd, logic [31:0] value);
      logic [7:0] index;
      index = regModel[10][9:2];
      @(posedge gclk);
      inst <= encodeTypeA(opAlu, rd, 5'd0, 5'd0);
      result <= value;
      instValid <= 1'b1;
      @(posedge gclk);
      inst <= encodeTypeB(opSwi, rd, 5'd10, 16'd0);
      @(posedge gclk);
      instValid <= 1'b0;
      waitRetire();
      regModel[rd] = value;
      memModel[index] = value;
      debugCheck(name, index);
   endtask

   task automatic loadWithDebugRead(string name, logic [4:0] rd, logic [7:0] dbgIndex);
      logic [7:0] index;
      logic dbgSeen;
      logic retired;
      int cycles;
      index = regModel[10][9:2];
      dbgSeen = 1'b0;
      retired = 1'b0;
      cycles = 0;
      @(posedge gclk);
      inst <= encodeTypeB(opLwi, rd, 5'd10, 16'd0);
      instValid <= 1'b1;
      @(posedge gclk);
      // debug asks in the cycle the load first requests
      instValid <= 1'b0;
      dbgReq <= 1'b1;
      dbgWe <= 1'b0;
      dbgAddr <= dbgIndex;
      dbgSel <= 4'hf;
      @(posedge gclk);
      dbgReq <= 1'b0;
      while (!retired) begin
         if (cycles == timeoutCycles) begin
            abortRun("load retire never came after the debug read");
         end else begin
            cycles++;
            @(negedge gclk);
            if (dbgAck) begin
               dbgSeen = 1'b1;
               assert (dbgRdata == memModel[dbgIndex])
                  else reportMismatch({name, " dbgRdata"}, memModel[dbgIndex], dbgRdata);
            end
            if (retire) begin
               assert (dbgSeen) else abortRun("load retired before the debug ack");
               retired = 1'b1;
            end
         end
      end
      if (rd != 5'd0) begin
         regModel[rd] = memModel[index];
      end
      checkRegs(name, rd, 5'd10);
   endtask

   initial begin
      seed = 95060;
      gclk = 1'b0;
      rstN = 1'b0;
      inst = '0;
      instValid = 1'b0;
      result = '0;
      pcLink = '0;
      dbgReq = 1'b0;
      dbgWe = 1'b0;
      dbgAddr = '0;
      dbgWdata = '0;
      dbgSel = '0;
      for (int i = 0; i < 32; i++) begin
         regModel[i] = '0;
      end
      for (int i = 0; i < 256; i++) begin
         memModel[i] = '0;
      end
      repeat (3) @(posedge gclk);
      rstN <= 1'b1;

      // random ALU writes, then every register read back
      for (int k = 0; k < 10; k++) begin
         rnd = $random(seed);
         writeReg(rnd[4:0], $random(seed));
      end
      writeReg(5'd0, 32'h12345678);
      for (int k = 0; k < 32; k += 2) begin
         checkRegs("aluRead", 5'(k), 5'(k + 1));
      end

      rnd = $random(seed);
      writeLink(5'd9, rnd[29:0]);
      checkRegs("link", 5'd9, 5'd0);

      // sized stores over a random old word, type A then type B
      writeReg(5'd10, 32'h00000040);
      for (int k = 0; k < 12; k++) begin
         rnd = $random(seed);
         isB = (k >= 6);
         opc = {2'b11, isB, 1'b1, 2'(k % 3)};
         imm = {{12{rnd[3]}}, rnd[3:0]};
         writeReg(5'd11, {28'd0, rnd[7:4]});
         writeReg(5'd12, $random(seed));
         addr = effectiveAddr(opc, 5'd10, 5'd11, imm);
         debugWriteWord(addr[9:2], $random(seed));
         memOp($sformatf("store%0d", k), opc, 5'd12, 5'd10, 5'd11, imm);
      end

      // sized loads, the last one with a negative immediate
      for (int k = 0; k < 12; k++) begin
         rnd = $random(seed);
         isB = (k >= 6);
         opc = {2'b11, isB, 1'b0, 2'(k % 3)};
         imm = (k == 11) ? 16'hfff8 : {{12{rnd[3]}}, rnd[3:0]};
         writeReg(5'd11, {28'd0, rnd[7:4]});
         addr = effectiveAddr(opc, 5'd10, 5'd11, imm);
         debugWriteWord(addr[9:2], $random(seed));
         memOp($sformatf("load%0d", k), opc, 5'd13, 5'd10, 5'd11, imm);
      end

      aluThenStore("forward0", 5'd14, $random(seed));
      aluThenStore("forward1", 5'd14, $random(seed));

      debugWriteWord(8'h10, $random(seed));
      debugWriteWord(8'h33, $random(seed));
      loadWithDebugRead("dbgFirst", 5'd15, 8'h33);

      @(posedge gclk);
      if (u_regLsuTop.u_regLsuAssert.anyFailure) begin
         abortRun("a concurrent assertion failed");
      end else begin
         $display("all tests passed");
         $finish;
      end
   end

endmodule

// File: regLsuTop.f
aexmPkg.sv
memBusIf.sv
regBank.sv
regFile.sv
lsuPort.sv
busArbiter.sv
dataRam.sv
regLsuTop.sv
regLsu_assert.sv
regLsuTb.sv

// File: Makefile
TOP = regLsuTb

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f regLsuTop.f -Mdir obj_dir -o $(TOP)

run: compile
	./obj_dir/$(TOP) +verilator+error+limit+10 | tee sim.log
	grep -q "all tests passed" sim.log

clean:
	rm -rf obj_dir sim.log
